// ==== include/demodRouter_cfg.svh ====
//****************************************
// Demod router configuration
// Widths, version, mode and DAC select codes, host address map
//****************************************

`ifndef DEMOD_ROUTER_CFG_SVH
`define DEMOD_ROUTER_CFG_SVH

// Datapath widths
`define SAMPLE_WIDTH        18
`define DAC_OUT_WIDTH       14
`define HOST_ADDR_WIDTH     12
`define HOST_DATA_WIDTH     16

`define VERSION_NUMBER      16'h0150

//****************************************
// Demodulation modes
//****************************************
`define MODE_FM             4'h1
`define MODE_2FSK           4'h2
`define MODE_PCMTRELLIS     4'h6
`define MODE_SOQPSK         4'h7
`define MODE_MULTIH         4'h8

// DAC selects that route to the trellis engines
`define DAC_TRELLIS_I       4'hA
`define DAC_TRELLIS_Q       4'hB
`define DAC_TRELLIS_PHERR   4'hC
`define DAC_TRELLIS_INDEX   4'hD

//****************************************
// Host address map
//****************************************
// Word addresses with bit 1 clear, bit 1 of the bus address picks the hi half
`define ADDR_CONTROL        12'h100
`define ADDR_VERSION        12'h104
`define ADDR_CLOCK          12'h108

`endif

// ==== rtl/demodRouterPkg.sv ====
//****************************************
// Demod router types
// Host bus, symbol streams, DAC samples, control register
//****************************************

`include "demodRouter_cfg.svh"

package demodRouterPkg;

    // Host request, one strobe per cycle at most
    typedef struct packed {
        logic                         wrStrobe;
        logic                         rdStrobe;
        logic [`HOST_ADDR_WIDTH-1:0]  addr;
        logic [`HOST_DATA_WIDTH-1:0]  wrData;
    } hostReq_t;

    typedef struct packed {
        logic                         rdValid;
        logic [`HOST_DATA_WIDTH-1:0]  rdData;
    } hostRsp_t;

    typedef logic [3:0] modeCode_t;
    typedef logic [3:0] dacSelect_t;

    // Mode sits in the low nibble
    typedef struct packed {
        dacSelect_t  dac2Select;
        dacSelect_t  dac1Select;
        dacSelect_t  dac0Select;
        modeCode_t   mode;
    } controlReg_t;

    // Trellis decision stream
    typedef struct packed {
        logic  symEn;
        logic  sym2xEn;
        logic  symBit;
    } symStream_t;

    typedef struct packed {
        logic  symEn;
        logic  sym2xEn;
        logic  iBit;
        logic  qBit;
    } legacySym_t;

    typedef struct packed {
        logic                       sync;
        logic [`SAMPLE_WIDTH-1:0]   data;
    } dacSample_t;

    typedef struct packed {
        logic [`HOST_DATA_WIDTH-1:0]  hi;
        logic [`HOST_DATA_WIDTH-1:0]  lo;
    } hostHalves_t;

    // 32-bit read word, seen whole or as two bus halves
    typedef union packed {
        logic [31:0]  raw;
        hostHalves_t  halves;
    } hostWord_u;

endpackage

// ==== rtl/hostRegisters.sv ====
//****************************************
// Host register block
// Decodes host strobes, holds the control register,
// returns version and counter words on reads
//****************************************

`include "demodRouter_cfg.svh"

module hostRegisters (
    input  logic                         ck933,
    input  logic                         clockCounterEn,
    input  demodRouterPkg::hostReq_t     req,
    input  logic [31:0]                  counterValue,
    output demodRouterPkg::hostRsp_t     rsp,
    output demodRouterPkg::controlReg_t  control,
    output logic                         counterRestart,
    output logic                         sampleStrobe
);

    import demodRouterPkg::*;

    logic [`HOST_ADDR_WIDTH-1:0]  wordAddr;
    logic                         controlHit;
    logic                         versionHit;
    logic                         clockHit;
    hostWord_u                    readWord;
    logic [`HOST_DATA_WIDTH-1:0]  readHalf;

    //****************************************
    // Address decode
    //****************************************
    assign wordAddr   = {req.addr[`HOST_ADDR_WIDTH-1:2], 2'b00};
    assign controlHit = (wordAddr == `ADDR_CONTROL);
    assign versionHit = (wordAddr == `ADDR_VERSION);
    assign clockHit   = (wordAddr == `ADDR_CLOCK);

    // Either half restarts the counter
    assign counterRestart = req.wrStrobe && clockHit;

    // Hi half read takes the sample, lo half then reads the held copy
    assign sampleStrobe = req.rdStrobe && clockHit && req.addr[1];

    // Control register lives in the lo half only
    always_ff @(posedge ck933 or posedge clockCounterEn) begin
        if (clockCounterEn) begin
            control <= '0;
        end
        else if (req.wrStrobe && controlHit && !req.addr[1]) begin
            control <= controlReg_t'(req.wrData);
        end
    end

    //****************************************
    // Read data
    //****************************************
    always_comb begin
        readWord.raw = '0;
        if (controlHit) begin
            readWord.halves.lo = control;
        end
        else if (versionHit) begin
            readWord.halves.hi = `VERSION_NUMBER;
        end
        else if (clockHit) begin
            readWord.raw = counterValue;
        end
    end

    assign readHalf = req.addr[1] ? readWord.halves.hi : readWord.halves.lo;

    // One cycle read latency and data cleared when idle
    always_ff @(posedge ck933 or posedge clockCounterEn) begin
        if (clockCounterEn) begin
            rsp <= '0;
        end
        else begin
            rsp.rdValid <= req.rdStrobe;
            rsp.rdData  <= req.rdStrobe ? readHalf : '0;
        end
    end

    //****************************************
    // Bus protocol checks
    //****************************************
    strobeExclusive: assert property (
        @(posedge ck933) disable iff (clockCounterEn)
        !(req.rdStrobe && req.wrStrobe)
    );

endmodule

// ==== rtl/cycleCounter.sv ====
//****************************************
// Cycle counter
// Free-running 32-bit count, restarted by the host,
// sampled into a hold register for reads
//****************************************

module cycleCounter (
    input  logic         ck933,
    input  logic         clockCounterEn,
    input  logic         counterRestart,
    input  logic         sampleStrobe,
    output logic [31:0]  counterValue
);

    logic [31:0]  count;
    logic [31:0]  hold;

    // Zero in the cycle after the restart write
    always_ff @(posedge ck933 or posedge clockCounterEn) begin
        if (clockCounterEn) begin
            count <= '0;
        end
        else if (counterRestart) begin
            count <= '0;
        end
        else begin
            count <= count + 32'd1;
        end
    end

    always_ff @(posedge ck933 or posedge clockCounterEn) begin
        if (clockCounterEn) begin
            hold <= '0;
        end
        else if (sampleStrobe) begin
            hold <= count;
        end
    end

    // Live count while the sample is being taken, so the strobed read
    // sees the same value that lands in the hold register
    assign counterValue = sampleStrobe ? count : hold;

endmodule

// ==== rtl/symbolSelect.sv ====
//****************************************
// Symbol select
// Mode-gated choice of output data bit and symbol enables
//****************************************

`include "demodRouter_cfg.svh"

module symbolSelect (
    input  logic                        ck933,
    input  logic                        clockCounterEn,
    input  demodRouterPkg::modeCode_t   mode,
    input  demodRouterPkg::symStream_t  pcmSym,
    input  demodRouterPkg::symStream_t  soqpskSym,
    input  demodRouterPkg::legacySym_t  legacySym,
    output logic                        dataSymEn,
    output logic                        dataSym2xEn,
    output logic                        iData,
    output logic                        qData
);

    import demodRouterPkg::*;

    logic        pcmMode;
    logic        trellisMode;
    logic        fmModes;
    symStream_t  trellisIn;
    symStream_t  trellisStage;
    legacySym_t  legacyStage;

    assign pcmMode     = (mode == `MODE_PCMTRELLIS);
    assign trellisMode = pcmMode || (mode == `MODE_SOQPSK);
    assign fmModes     = (mode == `MODE_FM) || (mode == `MODE_2FSK);

    // PCM trellis decision comes out with reversed polarity
    always_comb begin
        trellisIn = pcmMode ? pcmSym : soqpskSym;
        if (pcmMode) begin
            trellisIn.symBit = ~pcmSym.symBit;
        end
    end

    //****************************************
    // Stage one
    //****************************************
    always_ff @(posedge ck933 or posedge clockCounterEn) begin
        if (clockCounterEn) begin
            trellisStage <= '0;
            legacyStage  <= '0;
        end
        else begin
            trellisStage <= trellisIn;
            legacyStage  <= legacySym;
        end
    end

    //****************************************
    // Stage two
    //****************************************
    always_ff @(posedge ck933 or posedge clockCounterEn) begin
        if (clockCounterEn) begin
            dataSymEn   <= 1'b0;
            dataSym2xEn <= 1'b0;
            iData       <= 1'b0;
            qData       <= 1'b0;
        end
        else if (trellisMode) begin
            // Trellis bit goes out on both rails
            dataSymEn   <= trellisStage.symEn;
            dataSym2xEn <= trellisStage.sym2xEn;
            iData       <= trellisStage.symBit;
            qData       <= trellisStage.symBit;
        end
        else begin
            dataSymEn   <= legacyStage.symEn;
            dataSym2xEn <= legacyStage.sym2xEn;
            iData       <= fmModes ? ~legacyStage.iBit : legacyStage.iBit;
            qData       <= legacyStage.qBit;
        end
    end

endmodule

// ==== rtl/dacChannelMux.sv ====
//****************************************
// DAC channel mux
// Picks one channel's source sample and drives its top bits
//****************************************

`include "demodRouter_cfg.svh"

module dacChannelMux (
    input  logic                        ck933,
    input  logic                        clockCounterEn,
    input  demodRouterPkg::dacSelect_t  select,
    input  demodRouterPkg::modeCode_t   mode,
    input  demodRouterPkg::dacSample_t  demodSample,
    input  demodRouterPkg::dacSample_t  pcmSample,
    input  demodRouterPkg::dacSample_t  soqpskSample,
    input  demodRouterPkg::dacSample_t  multihSample,
    input  logic                        multihEn,
    output logic [`DAC_OUT_WIDTH-1:0]   dacData,
    output logic                        dacSync
);

    import demodRouterPkg::*;

    logic        trellisSelect;
    dacSample_t  chosen;

    always_comb begin
        case (select)
            `DAC_TRELLIS_I,
            `DAC_TRELLIS_Q,
            `DAC_TRELLIS_PHERR,
            `DAC_TRELLIS_INDEX: trellisSelect = 1'b1;
            default:            trellisSelect = 1'b0;
        endcase
    end

    // Source pick
    always_ff @(posedge ck933 or posedge clockCounterEn) begin
        if (clockCounterEn) begin
            chosen <= '0;
        end
        else if (trellisSelect) begin
            chosen <= (mode == `MODE_PCMTRELLIS) ? pcmSample : soqpskSample;
        end
        else if ((mode == `MODE_MULTIH) && multihEn) begin
            chosen <= multihSample;
        end
        else begin
            chosen <= demodSample;
        end
    end

    // Output register, upper bits of the sample
    always_ff @(posedge ck933 or posedge clockCounterEn) begin
        if (clockCounterEn) begin
            dacData <= '0;
            dacSync <= 1'b0;
        end
        else begin
            dacData <= chosen.data[`SAMPLE_WIDTH-1 -: `DAC_OUT_WIDTH];
            dacSync <= chosen.sync;
        end
    end

    // Select comes from the host control register
    selectKnown: assert property (
        @(posedge ck933) disable iff (clockCounterEn)
        !$isunknown(select)
    );

endmodule

// ==== rtl/demodRouter.sv ====
//****************************************
// Demod router top
// Host registers, cycle counter, symbol select, three DAC muxes
//****************************************

`include "demodRouter_cfg.svh"

module demodRouter (
    input  logic                              ck933,
    input  logic                              clockCounterEn,
    input  demodRouterPkg::hostReq_t          hostReq,
    input  demodRouterPkg::symStream_t        pcmSym,
    input  demodRouterPkg::symStream_t        soqpskSym,
    input  demodRouterPkg::legacySym_t        legacySym,
    input  demodRouterPkg::dacSample_t [2:0]  demodDac,
    input  demodRouterPkg::dacSample_t [2:0]  trellisPcmDac,
    input  demodRouterPkg::dacSample_t [2:0]  trellisSoqpskDac,
    input  demodRouterPkg::dacSample_t [2:0]  multihDac,
    input  logic [2:0]                        multihDacEn,
    input  logic                              bitsyncLock,
    input  logic                              carrierLock,
    input  logic                              multihLock,
    output demodRouterPkg::hostRsp_t          hostRsp,
    output demodRouterPkg::modeCode_t         demodMode,
    output logic                              dataSymEn,
    output logic                              dataSym2xEn,
    output logic                              iData,
    output logic                              qData,
    output logic [`DAC_OUT_WIDTH-1:0]         dac0,
    output logic [`DAC_OUT_WIDTH-1:0]         dac1,
    output logic [`DAC_OUT_WIDTH-1:0]         dac2,
    output logic                              dac0Sync,
    output logic                              dac1Sync,
    output logic                              dac2Sync,
    output logic                              bsyncNLock,
    output logic                              demodNLock
);

    import demodRouterPkg::*;

    controlReg_t                        control;
    logic [31:0]                        counterValue;
    logic                               counterRestart;
    logic                               sampleStrobe;
    dacSelect_t [2:0]                   dacSelects;
    logic [2:0][`DAC_OUT_WIDTH-1:0]     dacOut;
    logic [2:0]                         dacSyncOut;

    assign demodMode = control.mode;

    //****************************************
    // Host side
    //****************************************
    hostRegisters hostRegs (
        .ck933          (ck933),
        .clockCounterEn (clockCounterEn),
        .req            (hostReq),
        .counterValue   (counterValue),
        .rsp            (hostRsp),
        .control        (control),
        .counterRestart (counterRestart),
        .sampleStrobe   (sampleStrobe)
    );

    cycleCounter clockCounter (
        .ck933          (ck933),
        .clockCounterEn (clockCounterEn),
        .counterRestart (counterRestart),
        .sampleStrobe   (sampleStrobe),
        .counterValue   (counterValue)
    );

    symbolSelect symSelect (
        .ck933          (ck933),
        .clockCounterEn (clockCounterEn),
        .mode           (control.mode),
        .pcmSym         (pcmSym),
        .soqpskSym      (soqpskSym),
        .legacySym      (legacySym),
        .dataSymEn      (dataSymEn),
        .dataSym2xEn    (dataSym2xEn),
        .iData          (iData),
        .qData          (qData)
    );

    //****************************************
    // DAC channels
    //****************************************
    assign dacSelects = {control.dac2Select, control.dac1Select, control.dac0Select};

    for (genvar ch = 0; ch < 3; ch++) begin : dacChannel
        dacChannelMux dacMux (
            .ck933          (ck933),
            .clockCounterEn (clockCounterEn),
            .select         (dacSelects[ch]),
            .mode           (control.mode),
            .demodSample    (demodDac[ch]),
            .pcmSample      (trellisPcmDac[ch]),
            .soqpskSample   (trellisSoqpskDac[ch]),
            .multihSample   (multihDac[ch]),
            .multihEn       (multihDacEn[ch]),
            .dacData        (dacOut[ch]),
            .dacSync        (dacSyncOut[ch])
        );
    end

    assign dac0     = dacOut[0];
    assign dac1     = dacOut[1];
    assign dac2     = dacOut[2];
    assign dac0Sync = dacSyncOut[0];
    assign dac1Sync = dacSyncOut[1];
    assign dac2Sync = dacSyncOut[2];

    // Lock LEDs are active low
    assign bsyncNLock = ~bitsyncLock;
    assign demodNLock = (control.mode == `MODE_MULTIH) ? ~multihLock : ~carrierLock;

endmodule

// ==== verification/demodRouterTb.sv ====
//****************************************
// Demod router testbench
// Random host traffic and streams checked against a reference model
//****************************************

`include "demodRouter_cfg.svh"

module demodRouterTb;

    import demodRouterPkg::*;

    localparam int readTimeout  = 16;
    localparam int streamCycles = 24;

    logic                         ck933;
    logic                         clockCounterEn;
    hostReq_t                     hostReq;
    symStream_t                   pcmSym;
    symStream_t                   soqpskSym;
    legacySym_t                   legacySym;
    dacSample_t [2:0]             demodDac;
    dacSample_t [2:0]             trellisPcmDac;
    dacSample_t [2:0]             trellisSoqpskDac;
    dacSample_t [2:0]             multihDac;
    logic [2:0]                   multihDacEn;
    logic                         bitsyncLock;
    logic                         carrierLock;
    logic                         multihLock;
    hostRsp_t                     hostRsp;
    modeCode_t                    demodMode;
    logic                         dataSymEn;
    logic                         dataSym2xEn;
    logic                         iData;
    logic                         qData;
    logic [`DAC_OUT_WIDTH-1:0]    dac0;
    logic [`DAC_OUT_WIDTH-1:0]    dac1;
    logic [`DAC_OUT_WIDTH-1:0]    dac2;
    logic                         dac0Sync;
    logic                         dac1Sync;
    logic                         dac2Sync;
    logic                         bsyncNLock;
    logic                         demodNLock;

    integer       seed = 32'hd77e_181b;
    int           errors = 0;
    int           checks = 0;
    int           cycleCount = 0;
    int           restartCycle = 0;
    int           lastReadCycle = 0;
    controlReg_t  controlModel = '0;

    demodRouter UUT (
        .ck933            (ck933),
        .clockCounterEn   (clockCounterEn),
        .hostReq          (hostReq),
        .pcmSym           (pcmSym),
        .soqpskSym        (soqpskSym),
        .legacySym        (legacySym),
        .demodDac         (demodDac),
        .trellisPcmDac    (trellisPcmDac),
        .trellisSoqpskDac (trellisSoqpskDac),
        .multihDac        (multihDac),
        .multihDacEn      (multihDacEn),
        .bitsyncLock      (bitsyncLock),
        .carrierLock      (carrierLock),
        .multihLock       (multihLock),
        .hostRsp          (hostRsp),
        .demodMode        (demodMode),
        .dataSymEn        (dataSymEn),
        .dataSym2xEn      (dataSym2xEn),
        .iData            (iData),
        .qData            (qData),
        .dac0             (dac0),
        .dac1             (dac1),
        .dac2             (dac2),
        .dac0Sync         (dac0Sync),
        .dac1Sync         (dac1Sync),
        .dac2Sync         (dac2Sync),
        .bsyncNLock       (bsyncNLock),
        .demodNLock       (demodNLock)
    );

    initial begin
        ck933 = 1'b0;
        forever #2 ck933 = ~ck933;
    end

    // Cycle stamps for the counter model
    always @(posedge ck933) begin
        cycleCount <= cycleCount + 1;
    end

    //****************************************
    // Checking and reference model
    //****************************************
    task automatic checkValues(input logic [63:0] actual, input logic [63:0] expected,
                               input string msg);
        checks++;
        if (actual !== expected) begin
            $display("mismatch at time %0t: %s, got %0h expected %0h",
                     $time, msg, actual, expected);
            errors++;
        end
    endtask

    task automatic reportTest(input int num, input string name, input int startErrors);
        $display("test %0d (%s) finished with %0d errors", num, name, errors - startErrors);
    endtask

    // Output bits packed as {symEn, sym2xEn, i, q}
    function automatic logic [3:0] expectedSymbols(modeCode_t mode, symStream_t pcm,
                                                   symStream_t soq, legacySym_t leg);
        if (mode == `MODE_PCMTRELLIS) begin
            return {pcm.symEn, pcm.sym2xEn, ~pcm.symBit, ~pcm.symBit};
        end
        else if (mode == `MODE_SOQPSK) begin
            return {soq.symEn, soq.sym2xEn, soq.symBit, soq.symBit};
        end
        else if ((mode == `MODE_FM) || (mode == `MODE_2FSK)) begin
            return {leg.symEn, leg.sym2xEn, ~leg.iBit, leg.qBit};
        end
        return {leg.symEn, leg.sym2xEn, leg.iBit, leg.qBit};
    endfunction

    // Returns {sync, top bits} of the routed sample
    function automatic logic [14:0] expectedDac(dacSelect_t sel, modeCode_t mode,
                                                dacSample_t dem, dacSample_t pcm,
                                                dacSample_t soq, dacSample_t mh, logic en);
        dacSample_t src;
        if (sel inside {`DAC_TRELLIS_I, `DAC_TRELLIS_Q, `DAC_TRELLIS_PHERR,
                        `DAC_TRELLIS_INDEX}) begin
            src = (mode == `MODE_PCMTRELLIS) ? pcm : soq;
        end
        else if ((mode == `MODE_MULTIH) && en) begin
            src = mh;
        end
        else begin
            src = dem;
        end
        return {src.sync, src.data[`SAMPLE_WIDTH-1 -: `DAC_OUT_WIDTH]};
    endfunction

    function automatic modeCode_t pickMode();
        logic [31:0] r;
        r = $random(seed);
        case (r[2:0])
            3'd0:    return `MODE_FM;
            3'd1:    return `MODE_2FSK;
            3'd2:    return `MODE_PCMTRELLIS;
            3'd3:    return `MODE_SOQPSK;
            3'd4:    return `MODE_MULTIH;
            default: return r[7:4];
        endcase
    endfunction

    // Half the picks land on a trellis code
    function automatic dacSelect_t pickSelect();
        logic [31:0] r;
        r = $random(seed);
        if (r[0]) begin
            case (r[2:1])
                2'd0:    return `DAC_TRELLIS_I;
                2'd1:    return `DAC_TRELLIS_Q;
                2'd2:    return `DAC_TRELLIS_PHERR;
                default: return `DAC_TRELLIS_INDEX;
            endcase
        end
        return r[7:4];
    endfunction

    function automatic logic [15:0] randomControl(modeCode_t mode);
        return {pickSelect(), pickSelect(), pickSelect(), mode};
    endfunction

    //****************************************
    // Host bus tasks
    //****************************************
    task automatic writeReg(input logic [`HOST_ADDR_WIDTH-1:0] addr,
                            input logic [`HOST_DATA_WIDTH-1:0] data);
        hostReq_t req;
        req = '0;
        req.wrStrobe = 1'b1;
        req.addr = addr;
        req.wrData = data;
        @(posedge ck933);
        hostReq <= req;
        if (addr == `ADDR_CONTROL) begin
            controlModel = controlReg_t'(data);
        end
        if ({addr[`HOST_ADDR_WIDTH-1:2], 2'b00} == `ADDR_CLOCK) begin
            restartCycle = cycleCount;
        end
        @(posedge ck933);
        hostReq <= '0;
    endtask

    task automatic readReg(input logic [`HOST_ADDR_WIDTH-1:0] addr,
                           output logic [`HOST_DATA_WIDTH-1:0] data);
        hostReq_t req;
        int waitCycles;
        logic found;
        req = '0;
        req.rdStrobe = 1'b1;
        req.addr = addr;
        data = '0;
        found = 1'b0;
        waitCycles = 0;
        @(posedge ck933);
        hostReq <= req;
        lastReadCycle = cycleCount;
        @(posedge ck933);
        hostReq <= '0;
        while (!found && (waitCycles < readTimeout)) begin
            @(negedge ck933);
            waitCycles++;
            if (hostRsp.rdValid) begin
                found = 1'b1;
                data = hostRsp.rdData;
            end
        end
        if (!found) begin
            $display("read of address %0h got no response within %0d cycles",
                     addr, readTimeout);
            errors++;
        end
        else begin
            // Response is due one cycle after the strobe
            checkValues(64'(waitCycles), 64'd1, "read latency");
        end
    endtask

    //****************************************
    // Stream stimulus and two-cycle model pipes
    //****************************************
    task automatic runStreams(input int cycles);
        logic [63:0]       r;
        symStream_t        pcmV;
        symStream_t        soqV;
        legacySym_t        legV;
        dacSample_t [2:0]  demV;
        dacSample_t [2:0]  pcmD;
        dacSample_t [2:0]  soqD;
        dacSample_t [2:0]  mhD;
        logic [2:0]        enV;
        logic [2:0]        lockV;
        logic              expBsync;
        logic              expDemodLock;
        dacSelect_t [2:0]  sels;
        modeCode_t         mode;
        logic [3:0]        symQ[$];
        logic [44:0]       dacQ[$];
        logic [3:0]        expSym;
        logic [44:0]       expDacs;
        mode = controlModel.mode;
        sels = {controlModel.dac2Select, controlModel.dac1Select, controlModel.dac0Select};
        for (int i = 0; i < cycles; i++) begin
            @(posedge ck933);
            r = {$random(seed), $random(seed)};
            pcmV = r[2:0];
            soqV = r[5:3];
            legV = r[9:6];
            enV = r[12:10];
            lockV = r[15:13];
            r = {$random(seed), $random(seed)};
            demV = r[56:0];
            r = {$random(seed), $random(seed)};
            pcmD = r[56:0];
            r = {$random(seed), $random(seed)};
            soqD = r[56:0];
            r = {$random(seed), $random(seed)};
            mhD = r[56:0];
            pcmSym <= pcmV;
            soqpskSym <= soqV;
            legacySym <= legV;
            demodDac <= demV;
            trellisPcmDac <= pcmD;
            trellisSoqpskDac <= soqD;
            multihDac <= mhD;
            multihDacEn <= enV;
            bitsyncLock <= lockV[0];
            carrierLock <= lockV[1];
            multihLock <= lockV[2];
            symQ.push_back(expectedSymbols(mode, pcmV, soqV, legV));
            for (int ch = 0; ch < 3; ch++) begin
                expDacs[ch*15 +: 15] = expectedDac(sels[ch], mode, demV[ch], pcmD[ch],
                                                   soqD[ch], mhD[ch], enV[ch]);
            end
            dacQ.push_back(expDacs);
            @(negedge ck933);
            // Lock outputs are combinational
            expBsync = ~lockV[0];
            expDemodLock = (mode == `MODE_MULTIH) ? ~lockV[2] : ~lockV[1];
            checkValues(64'(bsyncNLock), 64'(expBsync), "bsyncNLock");
            checkValues(64'(demodNLock), 64'(expDemodLock), "demodNLock");
            if (symQ.size() == 3) begin
                expSym = symQ.pop_front();
                expDacs = dacQ.pop_front();
                checkValues(64'({dataSymEn, dataSym2xEn, iData, qData}), 64'(expSym),
                            "symbol outputs");
                checkValues(64'({dac2Sync, dac2, dac1Sync, dac1, dac0Sync, dac0}),
                            64'(expDacs), "DAC outputs");
            end
        end
    endtask

    //****************************************
    // Test sequence
    //****************************************
    initial begin : mainSequence
        logic [`HOST_DATA_WIDTH-1:0]  readBack;
        logic [`HOST_DATA_WIDTH-1:0]  hiWord;
        logic [`HOST_DATA_WIDTH-1:0]  loWord;
        logic [`HOST_ADDR_WIDTH-1:0]  addr;
        logic [31:0]                  r;
        logic [31:0]                  expCount;
        int                           startErrors;
        int                           sampleCycle;
        int                           gap;
        clockCounterEn <= 1'b1;
        hostReq <= '0;
        pcmSym <= '0;
        soqpskSym <= '0;
        legacySym <= '0;
        demodDac <= '0;
        trellisPcmDac <= '0;
        trellisSoqpskDac <= '0;
        multihDac <= '0;
        multihDacEn <= '0;
        bitsyncLock <= 1'b0;
        carrierLock <= 1'b0;
        multihLock <= 1'b0;
        repeat (3) @(posedge ck933);
        clockCounterEn <= 1'b0;

        startErrors = errors;
        repeat (2) @(posedge ck933);
        @(negedge ck933);
        checkValues(64'(demodMode), 64'd0, "demodMode after reset");
        checkValues(64'({dataSymEn, dataSym2xEn, iData, qData}), 64'd0, "data after reset");
        checkValues(64'({dac2Sync, dac2, dac1Sync, dac1, dac0Sync, dac0}), 64'd0,
                    "DAC outputs after reset");
        readReg(`ADDR_CONTROL, readBack);
        checkValues(64'(readBack), 64'd0, "control after reset");
        reportTest(1, "reset state", startErrors);

        startErrors = errors;
        repeat (8) begin
            writeReg(`ADDR_CONTROL, randomControl(pickMode()));
            readReg(`ADDR_CONTROL, readBack);
            checkValues(64'(readBack), 64'(controlModel), "control readback");
            @(negedge ck933);
            checkValues(64'(demodMode), 64'(controlModel.mode), "demodMode");
        end
        readReg(`ADDR_VERSION | 12'h002, readBack);
        checkValues(64'(readBack), 64'(`VERSION_NUMBER), "version hi");
        readReg(`ADDR_VERSION, readBack);
        checkValues(64'(readBack), 64'd0, "version lo");
        repeat (6) begin
            r = $random(seed);
            addr = r[`HOST_ADDR_WIDTH-1:0];
            // Move out of the mapped block
            if (addr[11:4] == 8'h10) begin
                addr[11] = 1'b1;
            end
            readReg(addr, readBack);
            checkValues(64'(readBack), 64'd0, "unmapped read");
        end
        reportTest(2, "host registers", startErrors);

        startErrors = errors;
        repeat (6) begin
            r = $random(seed);
            writeReg(r[0] ? (`ADDR_CLOCK | 12'h002) : `ADDR_CLOCK, r[31:16]);
            gap = 1 + int'(r[5:1]);
            repeat (gap) @(posedge ck933);
            // Hi half takes the sample, lo half reads the held copy
            readReg(`ADDR_CLOCK | 12'h002, hiWord);
            sampleCycle = lastReadCycle;
            readReg(`ADDR_CLOCK, loWord);
            expCount = 32'(sampleCycle - restartCycle - 1);
            checkValues(64'({hiWord, loWord}), 64'(expCount), "cycle counter sample");
        end
        reportTest(3, "cycle counter", startErrors);

        startErrors = errors;
        repeat (12) begin
            writeReg(`ADDR_CONTROL, randomControl(pickMode()));
            runStreams(streamCycles);
        end
        reportTest(4, "symbol selection", startErrors);

        startErrors = errors;
        repeat (16) begin
            writeReg(`ADDR_CONTROL, randomControl(pickMode()));
            runStreams(streamCycles);
        end
        reportTest(5, "DAC routing", startErrors);

        startErrors = errors;
        for (int i = 0; i < 8; i++) begin
            writeReg(`ADDR_CONTROL, randomControl(i[0] ? `MODE_MULTIH : pickMode()));
            runStreams(streamCycles);
        end
        reportTest(6, "lock indicators", startErrors);

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end
        else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+include
rtl/demodRouterPkg.sv
rtl/hostRegisters.sv
rtl/cycleCounter.sv
rtl/symbolSelect.sv
rtl/dacChannelMux.sv
rtl/demodRouter.sv
verification/demodRouterTb.sv

// ==== run.sh ====
#!/bin/bash
# Build and run the demod router testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module demodRouterTb -o simv \
    && ./obj_dir/simv | tee /dev/stderr | grep -q "No errors" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
